/* coreDefsPkg.sv */
`default_nettype none

package coreDefsPkg;

	// datapath and register file
	localparam int DataWidth = 32;
	localparam int RegIdWidth = 4; // 16 registers
	localparam logic [RegIdWidth-1:0] RegZero = '0;

	// one operation per lane, 4 bytes each
	localparam int OpWidth = 32;
	localparam int OpShift = 2;
	localparam int AddrWidth = 32;

	// operation fields
	localparam int OpcodeHi = 31;
	localparam int OpcodeLo = 28;
	localparam int DestHi = 27;
	localparam int DestLo = 24;
	localparam int SrcAHi = 23;
	localparam int SrcALo = 20;
	localparam int SrcBHi = 19;
	localparam int SrcBLo = 16;
	localparam int ImmHi = 15;
	localparam int ImmLo = 0;
	localparam int ImmWidth = ImmHi - ImmLo + 1;

	// codes above OpBra decode as NOP
	typedef enum logic [3:0] {
		OpNop = 4'd0,
		OpAdd = 4'd1,
		OpSub = 4'd2,
		OpAnd = 4'd3,
		OpOr = 4'd4,
		OpXor = 4'd5,
		OpAddi = 4'd6,
		OpBra = 4'd7
	} opcode_t;

endpackage

`default_nettype wire

/* issueIf.sv */
`timescale 1ns/10ps
`default_nettype none

// one decoded operation, issue registers to one execute lane
interface issueIf;
	import coreDefsPkg::*;

	logic valid;
	opcode_t opcode;
	logic [RegIdWidth-1:0] dest;
	logic [DataWidth-1:0] srcValA;
	logic [DataWidth-1:0] srcValB;
	logic [DataWidth-1:0] imm; // sign-extended for ADDI, raw for BRA

	modport issuer (
		output valid, opcode, dest, srcValA, srcValB, imm
	);

	modport lane (
		input valid, opcode, dest, srcValA, srcValB, imm
	);

endinterface

`default_nettype wire

/* resultIf.sv */
`timescale 1ns/10ps
`default_nettype none

// one lane result on its way to retire
interface resultIf;
	import coreDefsPkg::*;

	logic valid;
	logic [RegIdWidth-1:0] dest; // RegZero when nothing is written
	logic [DataWidth-1:0] value;
	logic branchTaken;
	logic [AddrWidth-1:0] branchTarget;

	modport lane (
		output valid, dest, value, branchTaken, branchTarget
	);

	modport retire (
		input valid, dest, value, branchTaken, branchTarget
	);

endinterface

`default_nettype wire

/* fetchUnit.sv */
`timescale 1ns/10ps
`default_nettype none

module fetchUnit #(
	parameter int LaneCount = 2,
	parameter int BundleShift = 3
) (
	input logic clock,
	input logic reset,
	input logic stall,
	input logic redirect,
	input logic [coreDefsPkg::AddrWidth-1:0] redirectAddr,
	output logic [coreDefsPkg::AddrWidth-1:0] fetchAddr,
	input logic [LaneCount*coreDefsPkg::OpWidth-1:0] fetchWord,
	output logic fetchValid,
	output logic [LaneCount*coreDefsPkg::OpWidth-1:0] fetchBundle
);
	import coreDefsPkg::*;

	localparam logic [AddrWidth-1:0] BundleBytes = AddrWidth'(1) << BundleShift;

	// program counter and fetch valid
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			fetchAddr <= '0;
			fetchValid <= 1'b0;
		end
		else if (redirect)
		begin
			// taken branch wins over an interlock
			fetchAddr <= redirectAddr;
			fetchValid <= 1'b0;
		end
		else if (!stall)
		begin
			fetchAddr <= fetchAddr + BundleBytes;
			fetchValid <= 1'b1;
		end
	end

	// memory answers in the same cycle, capture at the edge
	always_ff @(posedge clock)
	begin
		if (!stall)
			fetchBundle <= fetchWord;
	end

	// branch targets come from retire, must still land on a bundle
	fetchAligned: assert property (@(posedge clock) disable iff (reset)
		fetchAddr[BundleShift-1:0] == '0);

endmodule

`default_nettype wire

/* issueStage.sv */
`timescale 1ns/10ps
`default_nettype none

module issueStage #(
	parameter int LaneCount = 2
) (
	input logic clock,
	input logic reset,
	input logic fetchValid,
	input logic [LaneCount*coreDefsPkg::OpWidth-1:0] fetchBundle,
	input logic redirect,
	output logic stall,
	output logic [2*LaneCount-1:0][coreDefsPkg::RegIdWidth-1:0] readIdx,
	input logic [2*LaneCount-1:0][coreDefsPkg::DataWidth-1:0] readVal,
	issueIf.issuer lanes [LaneCount]
);
	import coreDefsPkg::*;

	logic [LaneCount-1:0] issValid;
	logic [LaneCount-1:0] issWrites; // issue reg will write a live register
	logic [RegIdWidth-1:0] issDest [LaneCount];
	logic [LaneCount-1:0] laneHazard;

	for (genvar l = 0; l < LaneCount; l++)
	begin : gLane
		logic [OpWidth-1:0] opWord;
		logic [RegIdWidth-1:0] srcA;
		logic [RegIdWidth-1:0] srcB;
		opcode_t decOp;
		logic readsA;
		logic readsB;
		logic [DataWidth-1:0] decImm;
		logic hazard;
		opcode_t issOp;
		logic [DataWidth-1:0] issA;
		logic [DataWidth-1:0] issB;
		logic [DataWidth-1:0] issImm;

		assign opWord = fetchBundle[l*OpWidth +: OpWidth]; // lane 0 in the low bits
		assign srcA = opWord[SrcAHi:SrcALo];
		assign srcB = opWord[SrcBHi:SrcBLo];
		assign readIdx[2*l] = srcA;
		assign readIdx[2*l+1] = srcB;

		always_comb
		begin
			decOp = opcode_t'(opWord[OpcodeHi:OpcodeLo]);
			if (decOp > OpBra)
				decOp = OpNop;
		end

		assign readsA = decOp inside {OpAdd, OpSub, OpAnd, OpOr, OpXor, OpAddi};
		assign readsB = decOp inside {OpAdd, OpSub, OpAnd, OpOr, OpXor};

		// ADDI sign-extends, BRA keeps the raw field
		assign decImm = (decOp == OpAddi) ?
			{{(DataWidth-ImmWidth){opWord[ImmHi]}}, opWord[ImmHi:ImmLo]} :
			DataWidth'(opWord[ImmHi:ImmLo]);

		// RAW against the bundle now sitting in the issue registers
		always_comb
		begin
			hazard = 1'b0;
			for (int k = 0; k < LaneCount; k++)
			begin
				if (issWrites[k] && ((readsA && srcA == issDest[k]) ||
					(readsB && srcB == issDest[k])))
					hazard = 1'b1;
			end
		end
		assign laneHazard[l] = hazard;

		always_ff @(posedge clock)
		begin
			issOp <= decOp;
			issDest[l] <= opWord[DestHi:DestLo];
			issA <= readVal[2*l];
			issB <= readVal[2*l+1];
			issImm <= decImm;
		end

		assign issWrites[l] = issValid[l] && (issDest[l] != RegZero) &&
			(issOp inside {OpAdd, OpSub, OpAnd, OpOr, OpXor, OpAddi});

		assign lanes[l].valid = issValid[l] && !redirect; // squashed by a retiring branch
		assign lanes[l].opcode = issOp;
		assign lanes[l].dest = issDest[l];
		assign lanes[l].srcValA = issA;
		assign lanes[l].srcValB = issB;
		assign lanes[l].imm = issImm;
	end

	assign stall = fetchValid && (|laneHazard);

	// stall and redirect both leave a bubble behind
	always_ff @(posedge clock)
	begin
		if (reset || stall || redirect)
			issValid <= '0;
		else
			issValid <= {LaneCount{fetchValid}};
	end

	// a flush must leave the fetch register empty
	flushEmptiesFetch: assert property (@(posedge clock) disable iff (reset)
		redirect |=> !fetchValid);

endmodule

`default_nettype wire

/* execLane.sv */
`timescale 1ns/10ps
`default_nettype none

module execLane #(
	parameter int BundleShift = 3
) (
	input logic clock,
	input logic reset,
	issueIf.lane op,
	resultIf.lane result
);
	import coreDefsPkg::*;

	logic [DataWidth-1:0] aluVal;
	logic writes;

	always_comb
	begin
		writes = 1'b1;
		case (op.opcode)
			OpAdd: aluVal = op.srcValA + op.srcValB;
			OpSub: aluVal = op.srcValA - op.srcValB;
			OpAnd: aluVal = op.srcValA & op.srcValB;
			OpOr: aluVal = op.srcValA | op.srcValB;
			OpXor: aluVal = op.srcValA ^ op.srcValB;
			OpAddi: aluVal = op.srcValA + op.imm;
			default:
			begin
				// NOP and BRA leave the registers alone
				aluVal = '0;
				writes = 1'b0;
			end
		endcase
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			result.valid <= 1'b0;
			result.branchTaken <= 1'b0;
		end
		else
		begin
			result.valid <= op.valid;
			result.branchTaken <= op.valid && (op.opcode == OpBra);
		end
	end

	always_ff @(posedge clock)
	begin
		result.dest <= writes ? op.dest : RegZero;
		result.value <= aluVal;
		result.branchTarget <= AddrWidth'(op.imm[ImmWidth-1:0]) << BundleShift; // bundle units
	end

	// ADDI adds the full word, so issue must hand over a sign-extended field
	immSignExtended: assert property (@(posedge clock) disable iff (reset)
		op.valid && op.opcode == OpAddi |->
			op.imm[DataWidth-1:ImmWidth] == {(DataWidth-ImmWidth){op.imm[ImmWidth-1]}});

endmodule

`default_nettype wire

/* retireUnit.sv */
`timescale 1ns/10ps
`default_nettype none

module retireUnit #(
	parameter int LaneCount = 2
) (
	resultIf.retire lanes [LaneCount],
	output logic [LaneCount-1:0] writeEn,
	output logic [LaneCount-1:0][coreDefsPkg::RegIdWidth-1:0] writeIdx,
	output logic [LaneCount-1:0][coreDefsPkg::DataWidth-1:0] writeVal,
	output logic redirect,
	output logic [coreDefsPkg::AddrWidth-1:0] redirectAddr,
	output logic [LaneCount-1:0] retireValid,
	output logic [LaneCount-1:0][coreDefsPkg::RegIdWidth-1:0] retireReg,
	output logic [LaneCount-1:0][coreDefsPkg::DataWidth-1:0] retireValue
);
	import coreDefsPkg::*;

	logic [LaneCount-1:0] taken;
	logic [AddrWidth-1:0] target [LaneCount];

	for (genvar l = 0; l < LaneCount; l++)
	begin : gLane
		assign taken[l] = lanes[l].valid && lanes[l].branchTaken;
		assign target[l] = lanes[l].branchTarget;
		assign writeEn[l] = lanes[l].valid && !lanes[l].branchTaken &&
			(lanes[l].dest != RegZero);
		assign writeIdx[l] = lanes[l].dest;
		assign writeVal[l] = lanes[l].value;
	end

	// same-register collisions are settled in the register file
	assign retireValid = writeEn;
	assign retireReg = writeIdx;
	assign retireValue = writeVal;

	// walk down so the lowest taken lane is the last one assigned
	always_comb
	begin
		redirect = 1'b0;
		redirectAddr = '0;
		for (int l = LaneCount - 1; l >= 0; l--)
		begin
			if (taken[l])
			begin
				redirect = 1'b1;
				redirectAddr = target[l];
			end
		end
	end

endmodule

`default_nettype wire

/* regFile.sv */
`timescale 1ns/10ps
`default_nettype none

module regFile #(
	parameter int LaneCount = 2,
	parameter int RegCount = 16
) (
	input logic clock,
	input logic reset,
	input logic [2*LaneCount-1:0][coreDefsPkg::RegIdWidth-1:0] readIdx,
	output logic [2*LaneCount-1:0][coreDefsPkg::DataWidth-1:0] readVal,
	input logic [LaneCount-1:0] writeEn,
	input logic [LaneCount-1:0][coreDefsPkg::RegIdWidth-1:0] writeIdx,
	input logic [LaneCount-1:0][coreDefsPkg::DataWidth-1:0] writeVal
);
	import coreDefsPkg::*;

	logic [DataWidth-1:0] regs [RegCount];

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			for (int r = 0; r < RegCount; r++)
				regs[r] <= '0;
		end
		else
		begin
			for (int l = 0; l < LaneCount; l++)
			begin
				if (writeEn[l] && writeIdx[l] != RegZero)
					regs[writeIdx[l]] <= writeVal[l]; // later lane overrides
			end
		end
	end

	// write-through bypass, same priority as the write port
	always_comb
	begin
		for (int r = 0; r < 2*LaneCount; r++)
		begin
			readVal[r] = regs[readIdx[r]];
			for (int l = 0; l < LaneCount; l++)
			begin
				if (writeEn[l] && writeIdx[l] == readIdx[r])
					readVal[r] = writeVal[l];
			end
			if (readIdx[r] == RegZero)
				readVal[r] = '0; // hard zero
		end
	end

endmodule

`default_nettype wire

/* dualIssueCore.sv */
`timescale 1ns/10ps
`default_nettype none

module dualIssueCore #(
	parameter int LaneCount = 2,
	parameter int RegCount = 16
) (
	input logic clock,
	input logic reset,
	output logic [coreDefsPkg::AddrWidth-1:0] fetchAddr,
	input logic [LaneCount*coreDefsPkg::OpWidth-1:0] fetchWord,
	output logic [LaneCount-1:0] retireValid,
	output logic [LaneCount-1:0][coreDefsPkg::RegIdWidth-1:0] retireReg,
	output logic [LaneCount-1:0][coreDefsPkg::DataWidth-1:0] retireValue,
	output logic stallOut
);
	import coreDefsPkg::*;

	localparam int BundleShift = OpShift + $clog2(LaneCount); // log2 of bundle bytes

	logic fetchValid;
	logic [LaneCount*OpWidth-1:0] fetchBundle;
	logic stall;
	logic redirect;
	logic [AddrWidth-1:0] redirectAddr;
	logic [2*LaneCount-1:0][RegIdWidth-1:0] readIdx;
	logic [2*LaneCount-1:0][DataWidth-1:0] readVal;
	logic [LaneCount-1:0] writeEn;
	logic [LaneCount-1:0][RegIdWidth-1:0] writeIdx;
	logic [LaneCount-1:0][DataWidth-1:0] writeVal;

	issueIf issueBus [LaneCount] ();
	resultIf resultBus [LaneCount] ();

	fetchUnit #(.LaneCount(LaneCount), .BundleShift(BundleShift)) fetch (
		.clock, .reset, .stall, .redirect, .redirectAddr,
		.fetchAddr, .fetchWord, .fetchValid, .fetchBundle
	);

	issueStage #(.LaneCount(LaneCount)) issue (
		.clock, .reset, .fetchValid, .fetchBundle, .redirect,
		.stall, .readIdx, .readVal, .lanes(issueBus)
	);

	regFile #(.LaneCount(LaneCount), .RegCount(RegCount)) regs (
		.clock, .reset, .readIdx, .readVal, .writeEn, .writeIdx, .writeVal
	);

	for (genvar l = 0; l < LaneCount; l++)
	begin : gLane
		execLane #(.BundleShift(BundleShift)) lane (
			.clock, .reset, .op(issueBus[l]), .result(resultBus[l])
		);
	end

	retireUnit #(.LaneCount(LaneCount)) retire (
		.lanes(resultBus), .writeEn, .writeIdx, .writeVal,
		.redirect, .redirectAddr, .retireValid, .retireReg, .retireValue
	);

	assign stallOut = stall;

endmodule

`default_nettype wire

/* tbProgram.svh */
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

localparam int ProgBundles = 19;

// arguments: bundle index, test, lane 0 op, lane 1 op
task automatic loadProgram();
	// alu seeds first, later bundles only need the bypass
	placeBundle(0, 1, encodeOp(OpAddi, 1, 0, 0, randomImm()),
		encodeOp(OpAddi, 2, 0, 0, randomImm()));
	placeBundle(1, 1, encodeOp(OpAddi, 3, 0, 0, randomImm()),
		encodeOp(OpAddi, 4, 0, 0, randomImm()));
	placeBundle(2, 1, encodeOp(OpAdd, 5, 1, 2, 0), encodeOp(OpAnd, 6, 1, 2, 0));
	placeBundle(3, 1, encodeOp(OpOr, 7, 3, 4, 0), encodeOp(OpXor, 8, 3, 4, 0));
	placeBundle(4, 1, encodeOp(OpSub, 9, 5, 1, 0),
		encodeOp(OpAddi, 10, 6, 0, randomImm()));
	// lane 1 reads the old r1
	placeBundle(5, 2, encodeOp(OpAddi, 1, 2, 0, randomImm()),
		encodeOp(OpAdd, 11, 1, 0, 0));
	placeBundle(6, 2, encodeOp(OpAddi, 12, 0, 0, randomImm()),
		encodeOp(OpAddi, 12, 3, 0, randomImm())); // both lanes write r12
	placeBundle(7, 2, encodeOp(OpAdd, 0, 5, 6, 0), encodeOp(OpNop, 0, 0, 0, 0));
	placeBundle(8, 2, encodeOp(OpOr, 13, 12, 0, 0), encodeOp(OpAdd, 14, 0, 0, 0));
	// each bundle needs the one right before it
	placeBundle(9, 3, encodeOp(OpAddi, 1, 1, 0, randomImm()),
		encodeOp(OpAddi, 2, 2, 0, randomImm()));
	placeBundle(10, 3, encodeOp(OpAdd, 3, 1, 2, 0), encodeOp(OpSub, 4, 2, 1, 0));
	placeBundle(11, 3, encodeOp(OpXor, 5, 3, 4, 0), encodeOp(OpAnd, 6, 3, 1, 0));
	placeBundle(12, 3, encodeOp(OpAddi, 7, 5, 0, randomImm()),
		encodeOp(OpOr, 8, 6, 5, 0));
	// lane 1 branch skips bundle 14, then a double branch follows lane 0
	placeBundle(13, 4, encodeOp(OpAddi, 9, 0, 0, randomImm()),
		encodeOp(OpBra, 0, 0, 0, 15));
	placeBundle(14, 4, encodeOp(OpAddi, 10, 0, 0, randomImm()),
		encodeOp(OpAddi, 11, 0, 0, randomImm()));
	placeBundle(15, 4, encodeOp(OpBra, 0, 0, 0, 17), encodeOp(OpBra, 0, 0, 0, 16));
	placeBundle(16, 4, encodeOp(OpAddi, 12, 0, 0, randomImm()),
		encodeOp(OpAddi, 13, 0, 0, randomImm()));
	placeBundle(17, 4, encodeOp(OpAdd, 10, 9, 7, 0),
		encodeOp(OpAddi, 11, 9, 0, randomImm()));
	placeBundle(18, 4, encodeOp(OpBra, 0, 0, 0, 18), encodeOp(OpNop, 0, 0, 0, 0)); // spin here
endtask

`endif

/* tbDualIssue.sv */
`timescale 1ns/10ps
`default_nettype none

module tbDualIssue;
	import coreDefsPkg::*;

	localparam int LaneCount = 2;
	localparam int BundleShift = 3; // 8-byte bundles
	localparam int ClockPeriod = 20;
	localparam int ResetCycles = 5;
	localparam int TestCount = 5;
	localparam int TestIdle = 0;
	localparam int TestInterlock = 3;
	localparam int MaxExp = 32;

	`include "tbProgram.svh"

	logic clock;
	logic reset;
	logic [AddrWidth-1:0] fetchAddr;
	logic [LaneCount*OpWidth-1:0] fetchWord;
	logic [LaneCount-1:0] retireValid;
	logic [LaneCount-1:0][RegIdWidth-1:0] retireReg;
	logic [LaneCount-1:0][DataWidth-1:0] retireValue;
	logic stallOut;

	logic [LaneCount*OpWidth-1:0] progMem [ProgBundles];
	int testOf [ProgBundles];
	logic [RegIdWidth-1:0] expReg [LaneCount][MaxExp];
	logic [DataWidth-1:0] expVal [LaneCount][MaxExp];
	int expTest [LaneCount][MaxExp];
	int expCount [LaneCount];
	int seen [LaneCount]; // retirements so far, per lane
	int checks [TestCount];
	int fails [TestCount];
	int stallHits [TestCount];
	int stallIdx;
	int seed = 32'hb7c7982e;

	dualIssueCore #(.LaneCount(LaneCount)) i_dut (
		.clock, .reset, .fetchAddr, .fetchWord,
		.retireValid, .retireReg, .retireValue, .stallOut
	);

	initial clock = 1'b0;
	always #(ClockPeriod / 2) clock = ~clock;

	function automatic logic [OpWidth-1:0] encodeOp(opcode_t code, int dest, int srcA,
		int srcB, int imm);
		return {code, RegIdWidth'(dest), RegIdWidth'(srcA), RegIdWidth'(srcB), ImmWidth'(imm)};
	endfunction

	task automatic placeBundle(int idx, int test, logic [OpWidth-1:0] op0,
		logic [OpWidth-1:0] op1);
		progMem[idx] = {op1, op0}; // lane 0 low
		testOf[idx] = test;
	endtask

	function automatic int randomImm();
		return $random(seed);
	endfunction

	function automatic string testName(int t);
		case (t)
			0: return "idle";
			1: return "alu";
			2: return "sameBundle";
			3: return "interlock";
			default: return "branch";
		endcase
	endfunction

	function automatic logic [DataWidth-1:0] computeOp(opcode_t code, logic [DataWidth-1:0] a,
		logic [DataWidth-1:0] b, logic [ImmWidth-1:0] imm);
		case (code)
			OpAdd: return a + b;
			OpSub: return a - b;
			OpAnd: return a & b;
			OpOr: return a | b;
			OpXor: return a ^ b;
			OpAddi: return a + {{(DataWidth-ImmWidth){imm[ImmWidth-1]}}, imm};
			default: return '0;
		endcase
	endfunction

	// in-order interpreter, fills the per-lane expected retirements
	task automatic buildExpected();
		logic [DataWidth-1:0] modelRegs [16];
		logic [LaneCount-1:0] wrEn;
		logic [RegIdWidth-1:0] wrIdx [LaneCount];
		logic [DataWidth-1:0] wrVal [LaneCount];
		logic [OpWidth-1:0] word;
		opcode_t code;
		logic taken;
		logic done;
		int pc;
		int nextPc;
		for (int r = 0; r < 16; r++)
			modelRegs[r] = '0;
		pc = 0;
		done = 1'b0;
		for (int step = 0; step < 4 * ProgBundles && !done; step++)
		begin
			taken = 1'b0;
			nextPc = pc + 1;
			for (int l = 0; l < LaneCount; l++)
			begin
				word = progMem[pc][l*OpWidth +: OpWidth];
				code = opcode_t'(word[OpcodeHi:OpcodeLo]);
				wrIdx[l] = word[DestHi:DestLo];
				wrEn[l] = (code inside {OpAdd, OpSub, OpAnd, OpOr, OpXor, OpAddi}) &&
					(wrIdx[l] != 0);
				// sources see the registers from before this bundle
				wrVal[l] = computeOp(code, modelRegs[word[SrcAHi:SrcALo]],
					modelRegs[word[SrcBHi:SrcBLo]], word[ImmHi:ImmLo]);
				if (code == OpBra && !taken)
				begin
					taken = 1'b1; // lowest lane wins
					nextPc = int'(word[ImmHi:ImmLo]);
				end
				if (wrEn[l])
				begin
					expReg[l][expCount[l]] = wrIdx[l];
					expVal[l][expCount[l]] = wrVal[l];
					expTest[l][expCount[l]] = testOf[pc];
					expCount[l]++;
				end
			end
			for (int l = 0; l < LaneCount; l++)
			begin
				if (wrEn[l])
					modelRegs[wrIdx[l]] = wrVal[l]; // lane 1 last
			end
			done = taken && (nextPc == pc);
			pc = nextPc;
		end
	endtask

	function automatic logic [LaneCount*OpWidth-1:0] readBundle(logic [AddrWidth-1:0] addr);
		int idx;
		idx = int'(addr >> BundleShift);
		if (idx < ProgBundles)
			return progMem[idx];
		return '0; // past the end reads as NOPs
	endfunction

	function automatic int entryTest(int l);
		if (seen[l] < expCount[l])
			return expTest[l][seen[l]];
		return expTest[l][expCount[l]-1];
	endfunction

	function automatic logic allSeen();
		for (int l = 0; l < LaneCount; l++)
		begin
			if (seen[l] < expCount[l])
				return 1'b0;
		end
		return 1'b1;
	endfunction

	task automatic reportRetire(int l);
		if (seen[l] >= expCount[l])
			$display("lane %0d retired r%0d = %h after its last expected result",
				l, retireReg[l], retireValue[l]);
		else
			$display("ERR %s lane %0d expected r%0d=%h actual r%0d=%h", testName(entryTest(l)),
				l, expReg[l][seen[l]], expVal[l][seen[l]], retireReg[l], retireValue[l]);
		fails[entryTest(l)]++;
	endtask

	// fetch memory answers the registered address
	always @(posedge clock)
	begin
		#2;
		fetchWord = readBundle(fetchAddr);
	end

	always @(posedge clock)
	begin
		if (!reset)
		begin
			for (int l = 0; l < LaneCount; l++)
			begin
				if (retireValid[l])
				begin
					checks[entryTest(l)]++;
					seen[l] <= seen[l] + 1;
				end
			end
		end
	end

	always @(negedge clock)
	begin
		stallIdx = int'(fetchAddr >> BundleShift) - 1; // bundle held in the fetch register
		if (reset)
			checks[TestIdle]++;
		else if (stallOut && stallIdx >= 0 && stallIdx < ProgBundles)
			stallHits[testOf[stallIdx]]++;
	end

	idleInReset: assert property (@(negedge clock)
		reset |-> (fetchAddr == '0 && retireValid == '0 && !stallOut))
	else
	begin
		$display("ERR %s expected fetchAddr=0 retireValid=0 stall=0 actual fetchAddr=%h %b %b",
			testName(TestIdle), fetchAddr, retireValid, stallOut);
		fails[TestIdle]++;
	end

	for (genvar l = 0; l < LaneCount; l++)
	begin : gCheck
		retireMatch: assert property (@(negedge clock) disable iff (reset)
			retireValid[l] |-> (seen[l] < expCount[l] &&
				retireReg[l] == expReg[l][seen[l]] && retireValue[l] == expVal[l][seen[l]]))
		else
			reportRetire(l);
	end

	task automatic printReport();
		int total;
		int failed;
		total = 0;
		failed = 0;
		for (int t = 0; t < TestCount; t++)
		begin
			$display("test %-10s checks %0d passed %0d failed %0d", testName(t), checks[t],
				checks[t] - fails[t], fails[t]);
			total += checks[t];
			failed += fails[t];
		end
		$display("total checks %0d passed %0d failed %0d", total, total - failed, failed);
		if (failed == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	endtask

	// 20 cycles per bundle plus reset
	initial
	begin
		#((ProgBundles * 20 + ResetCycles) * ClockPeriod);
		$display("watchdog expired, lane 0 saw %0d of %0d and lane 1 %0d of %0d retirements",
			seen[0], expCount[0], seen[1], expCount[1]);
		$display("Something failed");
		$finish;
	end

	initial
	begin
		reset = 1'b1;
		fetchWord = '0;
		for (int t = 0; t < TestCount; t++)
		begin
			checks[t] = 0;
			fails[t] = 0;
			stallHits[t] = 0;
		end
		for (int l = 0; l < LaneCount; l++)
		begin
			expCount[l] = 0;
			seen[l] = 0;
		end
		loadProgram();
		buildExpected();
		repeat (ResetCycles) @(posedge clock);
		#2;
		reset = 1'b0;
		while (!allSeen())
			@(posedge clock);
		repeat (4) @(posedge clock); // room for a stray retirement
		checks[TestInterlock]++;
		stallSeen: assert (stallHits[TestInterlock] > 0)
		else
		begin
			$display("interlock test finished without stallOut ever going high");
			fails[TestInterlock]++;
		end
		printReport();
	end

endmodule

`default_nettype wire

/* list.f */
+incdir+.
coreDefsPkg.sv
issueIf.sv
resultIf.sv
fetchUnit.sv
issueStage.sv
execLane.sv
retireUnit.sv
regFile.sv
dualIssueCore.sv
tbDualIssue.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the dual-issue core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tbDualIssue \
	-f list.f -o simDualIssue
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/simDualIssue > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "Everything OK" sim.log; then
	exit 0
fi
echo "pass message not found in sim.log"
exit 1
